//--- build.f
+incdir+dv
source/mcu_cmd_pkg.sv
source/cmd_bus_if.sv
source/cfg_regs.sv
source/mem_addr_ptr.sv
source/mem_bus_master.sv
source/reply_mux.sv
source/mcu_cmd_top.sv
dv/mcu_cmd_asserts.sv
dv/tb_mcu_cmd.sv

//--- Bender.yml
package:
  name: mcu_cmd

sources:
  - files:
      - source/mcu_cmd_pkg.sv
      - source/cmd_bus_if.sv
      - source/cfg_regs.sv
      - source/mem_addr_ptr.sv
      - source/mem_bus_master.sv
      - source/reply_mux.sv
      - source/mcu_cmd_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/mcu_cmd_asserts.sv
      - dv/tb_mcu_cmd.sv

//--- dv/mcu_cmd_model.svh
`ifndef MCU_CMD_MODEL_SVH
`define MCU_CMD_MODEL_SVH

//////////////////////////////////////////////////////////////////////
// reference model
//////////////////////////////////////////////////////////////////////

mapper_t exp_mapper;
addr_t   exp_rom_mask;
addr_t   exp_sram_mask;
addr_t   exp_addr;
byte_t   exp_reply;
byte_t   ref_mem [addr_t];

// bus cycle expected from the last strobe
bit      exp_cycle;
bit      exp_we;
addr_t   exp_adr;
byte_t   exp_dat;

// unwritten bytes read back as a pattern of the full address
function automatic byte_t fill_byte(input addr_t a);
  return a[23:16] ^ {a[12:8], a[15:13]} ^ (a[7:0] + 8'h5c);
endfunction

function automatic byte_t ref_read(input addr_t a);
  return ref_mem.exists(a) ? ref_mem[a] : fill_byte(a);
endfunction

function automatic addr_t put_byte(input addr_t v, input byte_cnt_t pos, input byte_t data);
  addr_t r;
  r = v;
  if (pos == POS_HI) r[23:16] = data;
  if (pos == POS_MID) r[15:8] = data;
  if (pos == POS_LO) r[7:0] = data;
  return r;
endfunction

task automatic reset_expected();
  exp_mapper    = MAPPER_RESET;
  exp_rom_mask  = '0;
  exp_sram_mask = '0;
  exp_addr      = '0;
  exp_reply     = '0;
  exp_cycle     = 1'b0;
  ref_mem.delete();
endtask

task automatic apply_strobe(input byte_t cmd_b, input byte_cnt_t pos, input byte_t data);
  logic [3:0] cls;
  cls       = cmd_b[7:4];
  exp_cycle = 1'b0;
  if (pos == 1 && cls == CLS_MAPPER) exp_mapper = cmd_b[2:0];
  if (cls == CLS_ROM_MASK) exp_rom_mask = put_byte(exp_rom_mask, pos, data);
  if (cls == CLS_SRAM_MASK) exp_sram_mask = put_byte(exp_sram_mask, pos, data);
  if (cls == CLS_ADDR) begin
    // high byte clears the rest
    exp_addr = (pos == POS_HI) ? {data, 16'h0} : put_byte(exp_addr, pos, data);
  end
  if (cls == CLS_READ || (cls == CLS_WRITE && pos >= POS_HI)) begin
    exp_cycle = 1'b1;
    exp_we    = (cls == CLS_WRITE);
    exp_adr   = exp_addr;
    exp_dat   = data;
    if (exp_we) ref_mem[exp_addr] = data;
    else exp_reply = ref_read(exp_addr);
    if (cmd_b[AUTO_INC_BIT]) exp_addr = exp_addr + 24'd1;
  end
  if (cmd_b == CMD_SIGNATURE) exp_reply = SIGNATURE_BYTE;
  if (cmd_b == CMD_ECHO && pos >= POS_HI) exp_reply = data;
endtask

//////////////////////////////////////////////////////////////////////
// wishbone slave memory
//////////////////////////////////////////////////////////////////////

byte_t slave_mem [addr_t];

// request seen at each cycle start
addr_t obs_adr_q[$];
bit    obs_we_q[$];
byte_t obs_dat_q[$];

function automatic byte_t slave_read(input addr_t a);
  return slave_mem.exists(a) ? slave_mem[a] : fill_byte(a);
endfunction

// acks 0 to 3 cycles late
initial begin : wb_slave
  int unsigned ack_wait;
  bit          in_cycle;
  wb_ack   = 1'b0;
  wb_dat_r = '0;
  in_cycle = 1'b0;
  ack_wait = 0;
  forever begin
    @(posedge clk);
    #1;
    if (wb_ack) begin
      wb_ack   = 1'b0;
      in_cycle = 1'b0;
    end else if (wb_cyc && wb_stb) begin
      if (!in_cycle) begin
        in_cycle = 1'b1;
        ack_wait = $urandom_range(3, 0);
        obs_adr_q.push_back(wb_adr);
        obs_we_q.push_back(wb_we);
        obs_dat_q.push_back(wb_dat_w);
      end
      if (ack_wait > 0) begin
        ack_wait--;
      end else begin
        wb_ack = 1'b1;
        if (wb_we) slave_mem[wb_adr] = wb_dat_w;
        else wb_dat_r = slave_read(wb_adr);
      end
    end
  end
end

`endif

//--- dv/tb_mcu_cmd.sv
module tb_mcu_cmd
  import mcu_cmd_pkg::*;
();

  localparam int CLK_PERIOD      = 8;
  localparam int N_CFG           = 12;
  localparam int N_WR            = 10;
  localparam int N_RD            = 10;
  localparam int N_ID            = 8;
  localparam int N_MIX           = 40;
  localparam int N_FRAMES        = N_CFG + 2 * N_WR + 2 * N_RD + N_ID + N_MIX;
  localparam int MAX_FRAME_LEN   = 7;
  // strobe, longest gap, slowest bus cycle
  localparam int BYTE_CYCLES     = 1 + 4 + 6;
  localparam int WATCHDOG_CYCLES = 2 * N_FRAMES * MAX_FRAME_LEN * BYTE_CYCLES + 200;

  logic      clk = 1'b0;
  logic      rst;
  logic      cmd_ready;
  logic      param_ready;
  byte_t     cmd_data;
  byte_t     param_data;
  byte_cnt_t byte_cnt;
  byte_t     spi_data_out;
  mapper_t   mapper;
  addr_t     rom_mask;
  addr_t     saveram_mask;
  logic      busy;
  logic      wb_cyc;
  logic      wb_stb;
  logic      wb_we;
  addr_t     wb_adr;
  byte_t     wb_dat_w;
  byte_t     wb_dat_r;
  logic      wb_ack;

  int        errors = 0;
  byte_t     frame_params[$];
  addr_t     written_q[$];

  `include "mcu_cmd_model.svh"

  mcu_cmd_top uut (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // host side
  //////////////////////////////////////////////////////////////////////

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("Fail at %0t: %s is %0h, expected %0h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic wait_idle();
    while (busy) idle_cycles(1);
  endtask

  task automatic check_strobe();
    check_eq(mapper, exp_mapper, "mapper");
    check_eq(rom_mask, exp_rom_mask, "rom_mask");
    check_eq(saveram_mask, exp_sram_mask, "saveram_mask");
    check_eq(spi_data_out, exp_reply, "spi_data_out");
    check_eq(wb_stb, 1'b0, "wb_stb while idle");
    check_eq(obs_adr_q.size(), exp_cycle, "bus cycles for one strobe");
    if (exp_cycle && obs_adr_q.size() == 1) begin
      check_eq(obs_adr_q[0], exp_adr, "wb_adr");
      check_eq(obs_we_q[0], exp_we, "wb_we");
      if (exp_we) check_eq(obs_dat_q[0], exp_dat, "wb_dat_w");
    end
    obs_adr_q.delete();
    obs_we_q.delete();
    obs_dat_q.delete();
  endtask

  task automatic drive_strobe(input bit is_cmd, input byte_cnt_t pos, input byte_t data);
    wait_idle();
    cmd_ready   = is_cmd;
    param_ready = !is_cmd;
    byte_cnt    = pos;
    param_data  = data;
    idle_cycles(1);
    cmd_ready   = 1'b0;
    param_ready = 1'b0;
    apply_strobe(cmd_data, pos, data);
    wait_idle();
    check_strobe();
    idle_cycles($urandom_range(4, 1));
  endtask

  task automatic send_frame(input byte_t cmd_b);
    cmd_data = cmd_b;
    drive_strobe(1'b1, 8'd1, byte_t'($urandom));
    foreach (frame_params[i]) drive_strobe(1'b0, byte_cnt_t'(i + 2), frame_params[i]);
  endtask

  task automatic fill_params(input int n);
    frame_params.delete();
    repeat (n) frame_params.push_back(byte_t'($urandom));
  endtask

  function automatic addr_t pick_addr();
    if (written_q.size() > 0 && $urandom_range(1, 0) == 1)
      return written_q[$urandom_range(written_q.size() - 1, 0)];
    return addr_t'($urandom);
  endfunction

  task automatic load_addr(input addr_t a);
    frame_params = '{a[23:16], a[15:8], a[7:0]};
    send_frame({CLS_ADDR, 4'($urandom)});
  endtask

  // 0 addr, 1 rom mask, 2 sram mask, 3 mapper, 4 read, 5 write, 6 signature, 7 echo
  task automatic send_random_frame(input int kind);
    logic [3:0] cls_of [6] = '{CLS_ADDR, CLS_ROM_MASK, CLS_SRAM_MASK,
                               CLS_MAPPER, CLS_READ, CLS_WRITE};
    case (kind)
      0: fill_params($urandom_range(4, 1));
      1, 2: fill_params($urandom_range(4, 3));
      3: fill_params(0);
      4: fill_params($urandom_range(5, 0));
      5: fill_params($urandom_range(6, 1));
      6: fill_params($urandom_range(3, 0));
      default: fill_params($urandom_range(5, 1));
    endcase
    if (kind == 6) send_frame(CMD_SIGNATURE);
    else if (kind == 7) send_frame(CMD_ECHO);
    else send_frame({cls_of[kind], 4'($urandom)});
  endtask

  task automatic compare_memories();
    check_eq(slave_mem.num(), ref_mem.num(), "written byte count");
    foreach (ref_mem[a]) check_eq(slave_read(a), ref_mem[a], $sformatf("memory at %06h", a));
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h6bc6));
    rst         = 1'b1;
    cmd_ready   = 1'b0;
    param_ready = 1'b0;
    cmd_data    = '0;
    param_data  = '0;
    byte_cnt    = '0;
    reset_expected();
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;

    check_eq(mapper, MAPPER_RESET, "mapper after reset");
    check_eq(rom_mask, 0, "rom_mask after reset");
    check_eq(saveram_mask, 0, "saveram_mask after reset");
    check_eq(spi_data_out, 0, "spi_data_out after reset");
    check_eq(busy, 0, "busy after reset");
    check_eq(wb_cyc, 0, "wb_cyc after reset");
    check_eq(wb_stb, 0, "wb_stb after reset");

    repeat (N_CFG) send_random_frame($urandom_range(3, 1));

    // write bursts from fresh or reused addresses
    repeat (N_WR) begin
      addr_t a;
      a = pick_addr();
      written_q.push_back(a);
      load_addr(a);
      send_random_frame(5);
    end
    compare_memories();

    repeat (N_RD) begin
      load_addr(pick_addr());
      send_random_frame(4);
    end

    for (int i = 0; i < N_ID; i++) send_random_frame(6 + i % 2);

    repeat (N_MIX) send_random_frame($urandom_range(7, 0));
    compare_memories();

    $display("errors: %0d, assertion failures: %0d", errors,
             uut.u_mem_bus_master.u_asserts.fail_count);
    if (errors == 0 && uut.u_mem_bus_master.u_asserts.fail_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired, the test sequence did not finish in time");
    $display("Test failures found");
    $finish;
  end

endmodule

//--- dv/mcu_cmd_asserts.sv
module mcu_cmd_asserts
  import mcu_cmd_pkg::*;
(
  input logic       clk,
  input logic       rst,
  input bus_state_t state_q,
  input logic       wb_cyc,
  input logic       wb_stb,
  input logic       wb_we,
  input addr_t      wb_adr,
  input byte_t      wb_dat_w,
  input logic       wb_ack,
  input logic       advance,
  input logic       rd_valid
);

  // failed assertions, summed into the closing line of the testbench
  int unsigned fail_count = 0;

  a_stb_cyc: assert property (@(posedge clk) disable iff (rst) wb_stb == wb_cyc)
    else begin
      $error("wb_stb differs from wb_cyc");
      fail_count++;
    end

  // request frozen until the slave acks
  a_req_stable: assert property (@(posedge clk) disable iff (rst)
    (wb_cyc && !wb_ack) |=> ($stable(wb_adr) && $stable(wb_we) && $stable(wb_dat_w)))
    else begin
      $error("wishbone request changed before ack");
      fail_count++;
    end

  a_cyc_end: assert property (@(posedge clk) disable iff (rst)
    (wb_cyc && wb_ack) |=> !wb_cyc)
    else begin
      $error("wb_cyc still high after the ack edge");
      fail_count++;
    end

  a_ack_only: assert property (@(posedge clk) disable iff (rst)
    (advance || rd_valid) |-> (state_q == BUS_CYCLE && wb_ack))
    else begin
      $error("advance or rd_valid outside the ack edge");
      fail_count++;
    end

endmodule

bind mem_bus_master mcu_cmd_asserts u_asserts (.*);

//--- source/mcu_cmd_top.sv
module mcu_cmd_top
  import mcu_cmd_pkg::*;
(
  input  logic      clk,
  input  logic      rst,

  // framed host bytes
  input  logic      cmd_ready,
  input  logic      param_ready,
  input  byte_t     cmd_data,
  input  byte_t     param_data,
  input  byte_cnt_t byte_cnt,
  output byte_t     spi_data_out,

  // configuration
  output mapper_t   mapper,
  output addr_t     rom_mask,
  output addr_t     saveram_mask,
  output logic      busy,

  // wishbone master
  output logic      wb_cyc,
  output logic      wb_stb,
  output logic      wb_we,
  output addr_t     wb_adr,
  output byte_t     wb_dat_w,
  input  byte_t     wb_dat_r,
  input  logic      wb_ack
);

  addr_t addr;
  logic  advance;
  byte_t rd_data;
  logic  rd_valid;

  cmd_bus_if cmd_bus ();

  assign cmd_bus.cmd_ready   = cmd_ready;
  assign cmd_bus.param_ready = param_ready;
  assign cmd_bus.cmd_data    = cmd_data;
  assign cmd_bus.param_data  = param_data;
  assign cmd_bus.byte_cnt    = byte_cnt;

  // host holds off while a bus cycle runs
  assign busy = wb_cyc;

  //////////////////////////////////////////////////////////////////////
  // decoders
  //////////////////////////////////////////////////////////////////////

  cfg_regs u_cfg_regs (
    .clk          (clk),
    .rst          (rst),
    .cmd          (cmd_bus.sink),
    .mapper       (mapper),
    .rom_mask     (rom_mask),
    .saveram_mask (saveram_mask)
  );

  mem_addr_ptr u_mem_addr_ptr (
    .clk     (clk),
    .rst     (rst),
    .cmd     (cmd_bus.sink),
    .advance (advance),
    .addr    (addr)
  );

  mem_bus_master u_mem_bus_master (
    .clk      (clk),
    .rst      (rst),
    .cmd      (cmd_bus.sink),
    .addr     (addr),
    .advance  (advance),
    .rd_data  (rd_data),
    .rd_valid (rd_valid),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
  );

  reply_mux u_reply_mux (
    .clk          (clk),
    .rst          (rst),
    .cmd          (cmd_bus.sink),
    .rd_data      (rd_data),
    .rd_valid     (rd_valid),
    .spi_data_out (spi_data_out)
  );

endmodule

//--- source/reply_mux.sv
module reply_mux
  import mcu_cmd_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  cmd_bus_if.sink cmd,
  input  byte_t   rd_data,
  input  logic    rd_valid,
  output byte_t   spi_data_out
);

  logic any_strobe;
  logic is_sig;
  logic is_echo;

  assign any_strobe = cmd.cmd_ready || cmd.param_ready;
  assign is_sig     = (cmd.cmd_data == CMD_SIGNATURE);
  assign is_echo    = (cmd.cmd_data == CMD_ECHO);

  //////////////////////////////////////////////////////////////////////
  // reply register
  //////////////////////////////////////////////////////////////////////

  // shifted out on the next SPI transfer
  always_ff @(posedge clk) begin
    if (rst) begin
      spi_data_out <= '0;
    end else if (rd_valid) begin
      spi_data_out <= rd_data;
    end else if (any_strobe && is_sig) begin
      spi_data_out <= SIGNATURE_BYTE;
    end else if (cmd.param_ready && is_echo) begin
      // echo returns the byte just received
      spi_data_out <= cmd.param_data;
    end
  end

endmodule

//--- source/mem_bus_master.sv
module mem_bus_master
  import mcu_cmd_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  cmd_bus_if.sink cmd,
  input  addr_t   addr,
  output logic    advance,
  output byte_t   rd_data,
  output logic    rd_valid,
  output logic    wb_cyc,
  output logic    wb_stb,
  output logic    wb_we,
  output addr_t   wb_adr,
  output byte_t   wb_dat_w,
  input  byte_t   wb_dat_r,
  input  logic    wb_ack
);

  bus_state_t state_q;
  logic       we_q;
  logic       inc_q;
  logic       start_rd;
  logic       start_wr;
  logic       start;
  logic       ack_edge;

  // reads on any strobe, writes only on parameter bytes
  assign start_rd = (cmd.cmd_ready || cmd.param_ready) && (cmd.cmd_data[7:4] == CLS_READ);
  assign start_wr = cmd.param_ready && (cmd.cmd_data[7:4] == CLS_WRITE);
  assign start    = (state_q == BUS_IDLE) && (start_rd || start_wr);
  assign ack_edge = (state_q == BUS_CYCLE) && wb_ack;

  //////////////////////////////////////////////////////////////////////
  // cycle FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= BUS_IDLE;
      we_q    <= 1'b0;
      inc_q   <= 1'b0;
    end else begin
      case (state_q)
        BUS_IDLE: begin
          // strobes while busy never reach here
          if (start) begin
            state_q <= BUS_CYCLE;
            we_q    <= start_wr;
            inc_q   <= cmd.cmd_data[AUTO_INC_BIT];
          end
        end
        BUS_CYCLE: begin
          if (wb_ack) begin
            state_q <= BUS_IDLE;
            we_q    <= 1'b0;
          end
        end
        default: state_q <= BUS_IDLE;
      endcase
    end
  end

  // address and write byte frozen for the whole cycle
  always_ff @(posedge clk) begin
    if (start) begin
      wb_adr   <= addr;
      wb_dat_w <= cmd.param_data;
    end
  end

  assign wb_cyc = (state_q == BUS_CYCLE);
  assign wb_stb = wb_cyc;
  assign wb_we  = we_q;

  // ack edge results, taken by the pointer and reply registers
  assign advance  = ack_edge && inc_q;
  assign rd_valid = ack_edge && !we_q;
  assign rd_data  = wb_dat_r;

endmodule

//--- source/mem_addr_ptr.sv
module mem_addr_ptr
  import mcu_cmd_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  cmd_bus_if.sink cmd,
  input  logic    advance,
  output addr_t   addr
);

  logic load_frame;

  assign load_frame = cmd.param_ready && (cmd.cmd_data[7:4] == CLS_ADDR);

  //////////////////////////////////////////////////////////////////////
  // pointer update
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      addr <= '0;
    end else if (load_frame) begin
      case (cmd.byte_cnt)
        // high byte starts a fresh address
        POS_HI: begin
          addr[23:16] <= cmd.param_data;
          addr[15:0]  <= '0;
        end
        POS_MID: begin
          addr[15:8] <= cmd.param_data;
        end
        POS_LO: begin
          addr[7:0] <= cmd.param_data;
        end
        default: ;
      endcase
    end else if (advance) begin
      // wraps at 24 bits
      addr <= addr + addr_t'(1);
    end
  end

endmodule

//--- source/cfg_regs.sv
module cfg_regs
  import mcu_cmd_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  cmd_bus_if.sink   cmd,
  output mapper_t   mapper,
  output addr_t     rom_mask,
  output addr_t     saveram_mask
);

  logic [3:0] cls;

  assign cls = cmd.cmd_data[7:4];

  // mapper comes straight from the command byte
  always_ff @(posedge clk) begin
    if (rst) begin
      mapper <= MAPPER_RESET;
    end else if (cmd.cmd_ready && cls == CLS_MAPPER) begin
      mapper <= cmd.cmd_data[2:0];
    end
  end

  // masks take three parameter bytes, msb first
  always_ff @(posedge clk) begin
    if (rst) begin
      rom_mask     <= '0;
      saveram_mask <= '0;
    end else if (cmd.param_ready) begin
      if (cls == CLS_ROM_MASK) begin
        case (cmd.byte_cnt)
          POS_HI:  rom_mask[23:16] <= cmd.param_data;
          POS_MID: rom_mask[15:8]  <= cmd.param_data;
          POS_LO:  rom_mask[7:0]   <= cmd.param_data;
          default: ;
        endcase
      end

      if (cls == CLS_SRAM_MASK) begin
        case (cmd.byte_cnt)
          POS_HI:  saveram_mask[23:16] <= cmd.param_data;
          POS_MID: saveram_mask[15:8]  <= cmd.param_data;
          POS_LO:  saveram_mask[7:0]   <= cmd.param_data;
          default: ;
        endcase
      end
    end
  end

endmodule

//--- source/cmd_bus_if.sv
interface cmd_bus_if
  import mcu_cmd_pkg::*;
();

  // one-cycle strobes, never high together
  logic      cmd_ready;
  logic      param_ready;

  // held for the whole frame
  byte_t     cmd_data;
  byte_t     param_data;
  byte_cnt_t byte_cnt;

  modport sink (
    input cmd_ready,
    input param_ready,
    input cmd_data,
    input param_data,
    input byte_cnt
  );

endinterface

//--- source/mcu_cmd_pkg.sv
package mcu_cmd_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths fixed by the host protocol
  //////////////////////////////////////////////////////////////////////

  typedef logic [7:0]  byte_t;
  typedef logic [23:0] addr_t;
  typedef logic [2:0]  mapper_t;

  // 1 = command byte, parameters from 2 up
  typedef logic [7:0]  byte_cnt_t;

  typedef enum logic {
    BUS_IDLE,
    BUS_CYCLE
  } bus_state_t;

  //////////////////////////////////////////////////////////////////////
  // command decoding
  //////////////////////////////////////////////////////////////////////

  // upper nibble of the command byte
  localparam logic [3:0] CLS_ADDR      = 4'h0;
  localparam logic [3:0] CLS_ROM_MASK  = 4'h1;
  localparam logic [3:0] CLS_SRAM_MASK = 4'h2;
  localparam logic [3:0] CLS_MAPPER    = 4'h3;
  localparam logic [3:0] CLS_READ      = 4'h8;
  localparam logic [3:0] CLS_WRITE     = 4'h9;

  // full command bytes
  localparam byte_t CMD_SIGNATURE = 8'hF0;
  localparam byte_t CMD_ECHO      = 8'hFF;

  localparam byte_t SIGNATURE_BYTE = 8'hA5;

  // read/write commands advance the pointer when this bit is set
  localparam int AUTO_INC_BIT = 3;

  localparam mapper_t MAPPER_RESET = 3'd1;

  // parameter positions of a 24-bit value, msb first
  localparam byte_cnt_t POS_HI  = 8'd2;
  localparam byte_cnt_t POS_MID = 8'd3;
  localparam byte_cnt_t POS_LO  = 8'd4;

endpackage
